// ==== src/uart_ctrl_defs.svh ====
`ifndef uart_ctrl_defs_svh
`define uart_ctrl_defs_svh

// Clocking of the serial line
`define uc_clk_freq 10_000_000
`define uc_baud 115200
`define uc_clks_per_bit (`uc_clk_freq / `uc_baud)

// Command opcodes, one byte each
`define uc_op_write_weight 8'h01
`define uc_op_write_act 8'h02
`define uc_op_execute 8'h03
`define uc_op_read_result 8'h04
`define uc_op_status 8'h05

// Data bytes that follow a write opcode
`define uc_payload_bytes 4

`endif

// ==== src/uart_ctrl_pkg.sv ====
`default_nettype none

package uart_ctrl_pkg;

    // Opcode plus four payload bytes, payload[0] received first
    typedef struct packed {
        logic [7:0]      opcode;
        logic [3:0][7:0] payload;
    } cmd_t;

    // Control word towards the MLP accelerator
    typedef struct packed {
        logic        wf_push_col0;
        logic        wf_push_col1;
        logic        wf_reset;
        logic        init_act_valid;
        logic        start_mlp;
        logic        weights_ready;
        logic [7:0]  wf_data;
        logic [15:0] init_act_data;
    } mlp_ctrl_t;

    // Status coming back from the MLP
    typedef struct packed {
        logic [3:0]         state;
        logic [4:0]         cycle_cnt;
        logic signed [31:0] acc0;
    } mlp_status_t;

    typedef struct packed {
        logic [3:0] state;
        logic [3:0] cycle_lo;
    } status_fields_t;

    // Status reply, built field by field and sent as a raw byte
    typedef union packed {
        logic [7:0]     raw;
        status_fields_t fields;
    } status_byte_u;

endpackage

`default_nettype wire

// ==== src/uart_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_ctrl_defs.svh"

module uart_rx (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    output byte  rx_byte,
    output logic rx_valid
);

    localparam int clks_per_bit = `uc_clks_per_bit;
    localparam int half_bit = clks_per_bit / 2;
    localparam int cnt_w = $clog2(clks_per_bit);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;

    // Two flop synchroniser, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= rx_idle;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // Recheck the start bit at its centre to reject glitches
                    if (clk_cnt == cnt_w'(half_bit - 1)) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? rx_idle : rx_data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
                        clk_cnt <= '0;
                        // LSB arrives first
                        shift   <= {rx_sync, shift[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
                        state <= rx_idle;
                        // Framing error drops the byte
                        if (rx_sync) begin
                            rx_byte  <= shift;
                            rx_valid <= 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_ctrl_defs.svh"

module uart_tx (
    input  logic clk,
    input  logic rst,
    input  byte  tx_byte,
    input  logic tx_valid,
    output logic tx_ready,
    output logic tx
);

    localparam int clks_per_bit = `uc_clks_per_bit;
    localparam int cnt_w = $clog2(clks_per_bit);

    logic             busy;
    logic [9:0]       frame;
    logic [cnt_w-1:0] clk_cnt;
    logic [3:0]       bit_cnt;

    assign tx_ready = !busy;
    // Bit 0 of the frame is always the bit on the line
    assign tx = frame[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            frame   <= '1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (tx_valid) begin
                // Stop bit, data, start bit
                frame   <= {1'b1, tx_byte, 1'b0};
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
            clk_cnt <= '0;
            frame   <= {1'b1, frame[9:1]};
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/cmd_parser.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_ctrl_defs.svh"

module cmd_parser (
    input  logic                clk,
    input  logic                rst,
    input  byte                 rx_byte,
    input  logic                rx_valid,
    input  logic                resp_busy,
    output uart_ctrl_pkg::cmd_t cmd,
    output logic                cmd_valid
);

    typedef enum logic {
        wait_op,
        get_payload
    } parse_state_t;

    parse_state_t state;
    logic [1:0]   byte_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= wait_op;
            byte_cnt  <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (rx_valid) begin
                if (resp_busy) begin
                    // Reply in flight, the byte is lost
                    state <= wait_op;
                end else if (state == wait_op) begin
                    byte_cnt <= '0;
                    case (rx_byte)
                        `uc_op_write_weight,
                        `uc_op_write_act: begin
                            cmd.opcode <= rx_byte;
                            state      <= get_payload;
                        end
                        `uc_op_execute,
                        `uc_op_read_result,
                        `uc_op_status: begin
                            // Single byte commands
                            cmd.opcode <= rx_byte;
                            cmd_valid  <= 1'b1;
                        end
                        default: begin
                            // Unknown opcode is dropped
                        end
                    endcase
                end else begin
                    cmd.payload[byte_cnt] <= rx_byte;
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'(`uc_payload_bytes - 1)) begin
                        cmd_valid <= 1'b1;
                        state     <= wait_op;
                    end
                end
            end
        end
    end

    // Back ends expect isolated command strobes
    a_cmd_valid_single: assert property (
        @(posedge clk) disable iff (rst)
        cmd_valid |=> !cmd_valid
    );

endmodule

`default_nettype wire

// ==== src/mlp_load_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_ctrl_defs.svh"

module mlp_load_seq (
    input  logic                     clk,
    input  logic                     rst,
    input  uart_ctrl_pkg::cmd_t      cmd,
    input  logic                     cmd_valid,
    output uart_ctrl_pkg::mlp_ctrl_t mlp_ctrl
);

    typedef enum logic [1:0] {
        seq_idle,
        seq_weight,
        seq_act
    } seq_mode_t;

    seq_mode_t  mode;
    logic [1:0] step;

    // The parser holds cmd until the next command, far beyond these few cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            mode                    <= seq_idle;
            step                    <= '0;
            mlp_ctrl.wf_push_col0   <= 1'b0;
            mlp_ctrl.wf_push_col1   <= 1'b0;
            mlp_ctrl.wf_reset       <= 1'b0;
            mlp_ctrl.init_act_valid <= 1'b0;
            mlp_ctrl.start_mlp      <= 1'b0;
            mlp_ctrl.weights_ready  <= 1'b0;
            mlp_ctrl.wf_data        <= '0;
            mlp_ctrl.init_act_data  <= '0;
        end else begin
            mlp_ctrl.wf_push_col0   <= 1'b0;
            mlp_ctrl.wf_push_col1   <= 1'b0;
            mlp_ctrl.wf_reset       <= 1'b0;
            mlp_ctrl.init_act_valid <= 1'b0;
            mlp_ctrl.start_mlp      <= 1'b0;
            if (cmd_valid) begin
                step <= '0;
                case (cmd.opcode)
                    `uc_op_write_weight: begin
                        // Clear the FIFO before the pushes
                        mlp_ctrl.wf_reset <= 1'b1;
                        mode              <= seq_weight;
                    end
                    `uc_op_write_act: begin
                        mlp_ctrl.init_act_valid <= 1'b1;
                        mlp_ctrl.init_act_data  <= {cmd.payload[1], cmd.payload[0]};
                        mode                    <= seq_act;
                    end
                    `uc_op_execute: begin
                        mlp_ctrl.start_mlp     <= 1'b1;
                        mlp_ctrl.weights_ready <= 1'b0;
                    end
                    default: begin
                        // Read and status belong to the sender
                    end
                endcase
            end else if (mode == seq_weight) begin
                // Even steps feed column 0, odd steps column 1
                mlp_ctrl.wf_push_col0 <= !step[0];
                mlp_ctrl.wf_push_col1 <= step[0];
                mlp_ctrl.wf_data      <= cmd.payload[step];
                step                  <= step + 1'b1;
                if (step == 2'd3) begin
                    mlp_ctrl.weights_ready <= 1'b1;
                    mode                   <= seq_idle;
                end
            end else if (mode == seq_act) begin
                // Second activation row
                mlp_ctrl.init_act_valid <= 1'b1;
                mlp_ctrl.init_act_data  <= {cmd.payload[3], cmd.payload[2]};
                mode                    <= seq_idle;
            end
        end
    end

    a_one_column_push: assert property (
        @(posedge clk) disable iff (rst)
        !(mlp_ctrl.wf_push_col0 && mlp_ctrl.wf_push_col1)
    );

endmodule

`default_nettype wire

// ==== src/resp_sender.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_ctrl_defs.svh"

module resp_sender (
    input  logic                       clk,
    input  logic                       rst,
    input  uart_ctrl_pkg::cmd_t        cmd,
    input  logic                       cmd_valid,
    input  uart_ctrl_pkg::mlp_status_t mlp_status,
    output byte                        tx_byte,
    output logic                       tx_valid,
    input  logic                       tx_ready,
    output logic                       resp_busy
);

    import uart_ctrl_pkg::*;

    status_byte_u    status_b;
    logic [3:0][7:0] resp_buf;
    logic [1:0]      byte_idx;
    logic [1:0]      last_idx;
    logic [1:0]      next_idx;

    always_comb begin
        status_b.fields.state    = mlp_status.state;
        status_b.fields.cycle_lo = mlp_status.cycle_cnt[3:0];
    end

    assign next_idx = byte_idx + 2'd1;

    // Busy exactly while a reply byte is still waiting to be taken
    assign resp_busy = tx_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
            byte_idx <= '0;
            last_idx <= '0;
        end else if (cmd_valid && cmd.opcode == `uc_op_read_result) begin
            // acc0 goes out LSB first
            resp_buf <= mlp_status.acc0;
            tx_byte  <= mlp_status.acc0[7:0];
            byte_idx <= '0;
            last_idx <= 2'd3;
            tx_valid <= 1'b1;
        end else if (cmd_valid && cmd.opcode == `uc_op_status) begin
            tx_byte  <= status_b.raw;
            byte_idx <= '0;
            last_idx <= '0;
            tx_valid <= 1'b1;
        end else if (tx_valid && tx_ready) begin
            if (byte_idx == last_idx) begin
                tx_valid <= 1'b0;
            end else begin
                // Next byte queued right behind the accepted one
                byte_idx <= next_idx;
                tx_byte  <= resp_buf[next_idx];
            end
        end
    end

    a_tx_hold: assert property (
        @(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte)
    );

endmodule

`default_nettype wire

// ==== src/uart_ctrl_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_ctrl_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       uart_rx,
    output logic                       uart_tx,
    output uart_ctrl_pkg::mlp_ctrl_t   mlp_ctrl,
    input  uart_ctrl_pkg::mlp_status_t mlp_status
);

    import uart_ctrl_pkg::*;

    byte  rx_byte;
    logic rx_valid;
    cmd_t cmd;
    logic cmd_valid;
    logic resp_busy;
    byte  tx_byte;
    logic tx_valid;
    logic tx_ready;

    uart_rx rx_i (
        .clk     (clk),
        .rst     (rst),
        .rx      (uart_rx),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid)
    );

    cmd_parser parser_i (
        .clk      (clk),
        .rst      (rst),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .resp_busy(resp_busy),
        .cmd      (cmd),
        .cmd_valid(cmd_valid)
    );

    mlp_load_seq load_i (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .mlp_ctrl (mlp_ctrl)
    );

    resp_sender sender_i (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .mlp_status(mlp_status),
        .tx_byte   (tx_byte),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .resp_busy (resp_busy)
    );

    uart_tx tx_i (
        .clk     (clk),
        .rst     (rst),
        .tx_byte (tx_byte),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .tx      (uart_tx)
    );

endmodule

`default_nettype wire

// ==== verif/tb_uart_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_ctrl_defs.svh"

module tb_uart_ctrl;

    import uart_ctrl_pkg::*;

    localparam int bit_clks = `uc_clks_per_bit;
    localparam int wait_limit = 40 * bit_clks;

    // Kinds of control events seen by the monitor
    localparam int ev_reset = 0;
    localparam int ev_col0 = 1;
    localparam int ev_col1 = 2;
    localparam int ev_act = 3;
    localparam int ev_start = 4;

    logic        clk;
    logic        rst;
    logic        uart_rx;
    logic        uart_tx;
    mlp_ctrl_t   mlp_ctrl;
    mlp_status_t mlp_status;

    logic [31:0] lfsr_state = 32'h5f68_65e1;
    int          ev_kind_q[$];
    logic [15:0] ev_data_q[$];
    int          ev_cycle_q[$];
    logic [7:0]  resp_q[$];
    int          cycle_no = 0;
    int          frame_cnt = 0;
    int          last_stop_cycle = 0;
    logic        tx_prev = 1'b1;

    uart_ctrl_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .uart_rx   (uart_rx),
        .uart_tx   (uart_tx),
        .mlp_ctrl  (mlp_ctrl),
        .mlp_status(mlp_status)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic void log_event(input int kind, input logic [15:0] data);
        ev_kind_q.push_back(kind);
        ev_data_q.push_back(data);
        ev_cycle_q.push_back(cycle_no);
    endfunction

    // Monitor samples mid cycle, away from the edges the tests drive on
    always @(negedge clk) begin
        cycle_no = cycle_no + 1;
        if (!rst) begin
            if (mlp_ctrl.wf_reset) log_event(ev_reset, 16'h0);
            if (mlp_ctrl.wf_push_col0) log_event(ev_col0, {8'h0, mlp_ctrl.wf_data});
            if (mlp_ctrl.wf_push_col1) log_event(ev_col1, {8'h0, mlp_ctrl.wf_data});
            if (mlp_ctrl.init_act_valid) log_event(ev_act, mlp_ctrl.init_act_data);
            if (mlp_ctrl.start_mlp) log_event(ev_start, 16'h0);
            if (tx_prev && !uart_tx) frame_cnt = frame_cnt + 1;
        end
        tx_prev = uart_tx;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic idle_for(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx <= frame[i];
            if (i == 9) begin
                last_stop_cycle = cycle_no;
            end
            repeat (bit_clks - 1) @(posedge clk);
        end
    endtask

    task automatic send_write(input logic [7:0] op, input logic [31:0] pl);
        send_byte(op);
        for (int i = 0; i < 4; i++) begin
            send_byte(pl[8*i +: 8]);
        end
    endtask

    task automatic recv_byte(output logic [7:0] b);
        int n;
        n = 0;
        @(posedge clk);
        while (uart_tx !== 1'b0) begin
            if (n == wait_limit) fail_now("Timeout: no start bit seen on uart_tx");
            n++;
            @(posedge clk);
        end
        repeat (bit_clks / 2) @(posedge clk);
        check_value("uart_tx start bit", uart_tx, 0);
        for (int i = 0; i < 8; i++) begin
            repeat (bit_clks) @(posedge clk);
            b[i] = uart_tx;
        end
        repeat (bit_clks) @(posedge clk);
        check_value("uart_tx stop bit", uart_tx, 1);
    endtask

    task automatic collect(input int n);
        logic [7:0] b;
        for (int i = 0; i < n; i++) begin
            recv_byte(b);
            resp_q.push_back(b);
        end
    endtask

    // Reply starts before the opcode's stop bit ends, so listen in parallel
    task automatic request(input logic [7:0] op, input int n);
        resp_q.delete();
        fork
            send_byte(op);
            collect(n);
        join
    endtask

    task automatic wait_events(input int n, input string what);
        int t;
        t = 0;
        while (ev_kind_q.size() < n) begin
            if (t == wait_limit) fail_now({"Timeout: ", what, " never appeared"});
            t++;
            @(posedge clk);
        end
    endtask

    task automatic clear_events();
        ev_kind_q.delete();
        ev_data_q.delete();
        ev_cycle_q.delete();
    endtask

    task automatic check_event(input int idx, input int kind, input logic [15:0] data,
                               input int cycle);
        check_value($sformatf("event %0d kind", idx), ev_kind_q[idx], kind);
        check_value($sformatf("event %0d data", idx), ev_data_q[idx], data);
        check_value($sformatf("event %0d cycle", idx), ev_cycle_q[idx], cycle);
    endtask

    // Command ends at the centre of the last stop bit, so its first pulse lands inside that bit
    task automatic check_first_event(input int kind, input logic [15:0] data);
        check_value("event 0 kind", ev_kind_q[0], kind);
        check_value("event 0 data", ev_data_q[0], data);
        check_value("event 0 inside last stop bit",
                    (ev_cycle_q[0] > last_stop_cycle) &&
                    (ev_cycle_q[0] <= last_stop_cycle + bit_clks), 1);
    endtask

    task automatic test_after_reset();
        check_value("uart_tx", uart_tx, 1);
        check_value("mlp_ctrl", mlp_ctrl, 0);
        idle_for(3 * bit_clks);
        check_value("response frames", frame_cnt, 0);
        check_value("control events", ev_kind_q.size(), 0);
    endtask

    task automatic test_write_weights();
        logic [31:0] pl;
        int          base;
        clear_events();
        pl = rand_bits(32);
        send_write(`uc_op_write_weight, pl);
        wait_events(5, "weight load");
        idle_for(2 * bit_clks);
        check_value("weight event count", ev_kind_q.size(), 5);
        base = ev_cycle_q[0];
        check_first_event(ev_reset, 16'h0);
        // Columns alternate 0, 1, 0, 1 with payload bytes in order
        for (int i = 0; i < 4; i++) begin
            check_event(i + 1, (i % 2 == 0) ? ev_col0 : ev_col1,
                        {8'h0, pl[8*i +: 8]}, base + i + 1);
        end
        check_value("weights_ready", mlp_ctrl.weights_ready, 1);
    endtask

    task automatic test_write_acts();
        logic [31:0] pl;
        clear_events();
        pl = rand_bits(32);
        send_write(`uc_op_write_act, pl);
        wait_events(2, "activation writes");
        idle_for(2 * bit_clks);
        check_value("activation event count", ev_kind_q.size(), 2);
        check_first_event(ev_act, {pl[15:8], pl[7:0]});
        check_event(1, ev_act, {pl[31:24], pl[23:16]}, ev_cycle_q[0] + 1);
    endtask

    task automatic test_execute();
        clear_events();
        send_byte(`uc_op_execute);
        wait_events(1, "start_mlp pulse");
        idle_for(2 * bit_clks);
        check_value("execute event count", ev_kind_q.size(), 1);
        check_first_event(ev_start, 16'h0);
        check_value("weights_ready", mlp_ctrl.weights_ready, 0);
    endtask

    task automatic test_read_back();
        mlp_status_t st;
        st.state = 4'(rand_bits(4));
        st.cycle_cnt = 5'(rand_bits(5));
        st.acc0 = rand_bits(32);
        @(posedge clk);
        mlp_status <= st;
        clear_events();
        request(`uc_op_read_result, 4);
        for (int i = 0; i < 4; i++) begin
            check_value($sformatf("acc0 byte %0d", i), resp_q[i], st.acc0[8*i +: 8]);
        end
        request(`uc_op_status, 1);
        check_value("status byte", resp_q[0], {st.state, st.cycle_cnt[3:0]});
        check_value("control events", ev_kind_q.size(), 0);
    endtask

    task automatic test_unknown_opcode();
        int frames_before;
        clear_events();
        frames_before = frame_cnt;
        send_byte(8'hc3);
        idle_for(4 * bit_clks);
        check_value("control events", ev_kind_q.size(), 0);
        check_value("response frames", frame_cnt, frames_before);
        request(`uc_op_status, 1);
        check_value("status byte", resp_q[0],
                    {mlp_status.state, mlp_status.cycle_cnt[3:0]});
    endtask

    initial begin
        rst = 1'b1;
        uart_rx = 1'b1;
        mlp_status = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_after_reset();
        test_write_weights();
        test_write_acts();
        test_execute();
        test_read_back();
        test_unknown_opcode();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+src
src/uart_ctrl_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_parser.sv
src/mlp_load_seq.sv
src/resp_sender.sv
src/uart_ctrl_top.sv
verif/tb_uart_ctrl.sv
